//--- rtl/host_cfg_pkg.sv
// Host configuration definitions for the PDP-11 board glue.
// The status word layout follows the configuration menu option string.
// Bits 31:10 of the status word are not decoded.

package host_cfg_pkg;

    // ==================================================
    // Menu status word
    // ==================================================

    // Field order runs from bit 31 down to bit 0
    typedef struct packed {
        logic [21:0] spare;
        logic [2:0]  screen_off_sel;
        logic        cursor_blink;
        logic        cursor_block;
        logic        vt105_sel;
        logic [2:0]  model_sel;
        logic        reset_req;
    } host_status_t;

    // ==================================================
    // Decoded machine configuration
    // ==================================================

    typedef struct packed {
        logic [7:0]  model_code;
        logic [6:0]  vt_type;
        logic        cursor_block;
        logic        cursor_blink;
        logic [12:0] screen_off_seconds;
    } machine_cfg_t;

    // Terminal type codes as the VT emulator expects them
    localparam logic [6:0] VT_TYPE_100 = 7'd100;
    localparam logic [6:0] VT_TYPE_105 = 7'd105;

    // CPU model per menu selection, the two unused selections fall back to the 11/94
    localparam logic [7:0] MODEL_CODES [0:7] = '{
        8'd20, 8'd34, 8'd44, 8'd45, 8'd70, 8'd94, 8'd94, 8'd94
    };

    // Screen-off timeout in seconds, zero disables the timer
    localparam logic [12:0] SCREEN_OFF_SECONDS [0:7] = '{
        13'd0, 13'd60, 13'd120, 13'd240, 13'd600, 13'd1200, 13'd3600, 13'd7200
    };

    // ==================================================
    // Reset stretch
    // ==================================================

    localparam int RESET_CNT_W = 12;

    // Machine reset is held for this many cycles plus one after all sources drop
    localparam logic [RESET_CNT_W-1:0] SLOW_RESET_CYCLES = 12'd4095;

endpackage

//--- rtl/disk_pkg.sv
// Disk plumbing definitions shared by the presence and request blocks.
// Disk order is fixed as RL, RK, RH and matches the menu mount slots.

package disk_pkg;

    // ==================================================
    // Disk slots
    // ==================================================

    localparam int NUM_DISKS = 3;

    localparam int DISK_RL = 0;
    localparam int DISK_RK = 1;
    localparam int DISK_RH = 2;

    // ==================================================
    // SPI lines between a disk controller and its card
    // ==================================================

    typedef struct packed {
        logic cs;
        logic sclk;
        logic mosi;
    } spi_bus_t;

    // A deselected SPI bus idles with every line high
    localparam spi_bus_t SPI_IDLE = '{cs: 1'b1, sclk: 1'b1, mosi: 1'b1};

    // ==================================================
    // Block request from a virtual card to the host
    // ==================================================

    // rd and wr are single-cycle strobes, lba and buff_din are valid with them
    typedef struct packed {
        logic [31:0] lba;
        logic        rd;
        logic        wr;
        logic [7:0]  buff_din;
    } card_req_t;

endpackage

//--- rtl/reset_sequencer.sv
// Merges every reset source and stretches the result.
// Both outputs stay high for 4096 clk50m edges after the last source drops.
// Only button 1 acts as a reset button, button 0 is ignored.

`timescale 1ns/1ns

module reset_sequencer (
    input  logic       clk50m,
    input  logic       reset,
    input  logic       status_reset,
    input  logic [1:0] buttons,
    input  logic       ioctl_download,
    output logic       slow_reset,
    output logic       vt_reset
);
    import host_cfg_pkg::*;

    logic                   combined_reset;
    logic [RESET_CNT_W-1:0] stretch_cnt;

    // A running download must keep the machine in reset as well
    assign combined_reset = reset | status_reset | buttons[1] | ioctl_download;

    always_ff @(posedge clk50m) begin
        if (combined_reset) begin
            stretch_cnt <= SLOW_RESET_CYCLES;
            slow_reset  <= 1'b1;
            vt_reset    <= 1'b1;
        end else if (stretch_cnt == '0) begin
            // Both resets release on the same edge
            slow_reset <= 1'b0;
            vt_reset   <= 1'b0;
        end else begin
            stretch_cnt <= stretch_cnt - 1'b1;
        end
    end

    // ==================================================
    // Checks
    // ==================================================

    // Any active source must show up on both outputs after the next edge
    a_reset_held: assert property (
        @(posedge clk50m) combined_reset |=> (slow_reset && vt_reset)
    );

endmodule

//--- rtl/option_decoder.sv
// Decodes the menu status word into the machine configuration.
// The configuration is registered and follows the status one edge later.
// Reset loads the decode of an all-zero status word.

`timescale 1ns/1ns

module option_decoder (
    input  logic                      clk50m,
    input  logic                      reset,
    input  host_cfg_pkg::host_status_t status,
    output host_cfg_pkg::machine_cfg_t cfg
);
    import host_cfg_pkg::*;

    machine_cfg_t cfg_next;

    // ==================================================
    // Table lookups
    // ==================================================

    always_comb begin
        cfg_next.model_code         = MODEL_CODES[status.model_sel];
        cfg_next.vt_type            = status.vt105_sel ? VT_TYPE_105 : VT_TYPE_100;
        cfg_next.cursor_block       = status.cursor_block;
        cfg_next.cursor_blink       = status.cursor_blink;
        cfg_next.screen_off_seconds = SCREEN_OFF_SECONDS[status.screen_off_sel];
    end

    // ==================================================
    // Output register
    // ==================================================

    always_ff @(posedge clk50m) begin
        if (reset) begin
            // Model 20, vt100, underline cursor without blink, timer off
            cfg.model_code         <= MODEL_CODES[0];
            cfg.vt_type            <= VT_TYPE_100;
            cfg.cursor_block       <= 1'b0;
            cfg.cursor_blink       <= 1'b0;
            cfg.screen_off_seconds <= SCREEN_OFF_SECONDS[0];
        end else begin
            cfg <= cfg_next;
        end
    end

    // ==================================================
    // Checks
    // ==================================================

    // The terminal only understands the two VT codes
    a_vt_type_valid: assert property (
        @(posedge clk50m) disable iff (reset)
        (cfg.vt_type == VT_TYPE_100) || (cfg.vt_type == VT_TYPE_105)
    );

endmodule

//--- rtl/disk_presence.sv
// Tracks which disk images are mounted and gates the SPI lines.
// A card only sees its controller while a non-empty image is mounted.
// img_size is shared by all slots and sampled with that slot's mount strobe.
// The gating is combinational, so a glitch on a flag reaches the card.

`timescale 1ns/1ns

module disk_presence (
    input  logic                                          clk50m,
    input  logic                                          reset,
    input  logic [disk_pkg::NUM_DISKS-1:0]                img_mounted,
    input  logic [63:0]                                   img_size,
    input  disk_pkg::spi_bus_t [disk_pkg::NUM_DISKS-1:0] ctl_spi,
    input  logic [disk_pkg::NUM_DISKS-1:0]                card_miso,
    output disk_pkg::spi_bus_t [disk_pkg::NUM_DISKS-1:0] card_spi,
    output logic [disk_pkg::NUM_DISKS-1:0]                ctl_miso,
    output logic [disk_pkg::NUM_DISKS-1:0]                present
);
    import disk_pkg::*;

    logic image_nonempty;

    // A zero size means the slot was unmounted
    assign image_nonempty = |img_size;

    // ==================================================
    // Mounted flags
    // ==================================================

    always_ff @(posedge clk50m) begin
        if (reset) begin
            present <= '0;
        end else begin
            for (int i = 0; i < NUM_DISKS; i++) begin
                if (img_mounted[i]) begin
                    present[i] <= image_nonempty;
                end
            end
        end
    end

    // ==================================================
    // SPI gating per slot
    // ==================================================

    for (genvar i = 0; i < NUM_DISKS; i++) begin : g_slot
        // An absent card sees an idle bus, its controller reads an idle MISO
        assign card_spi[i] = present[i] ? ctl_spi[i] : SPI_IDLE;
        assign ctl_miso[i] = present[i] ? card_miso[i] : 1'b1;

        // With no image the card stays deselected
        a_absent_cs_high: assert property (
            @(posedge clk50m) disable iff (reset)
            !present[i] |-> card_spi[i].cs
        );
    end

endmodule

//--- rtl/sd_request_mux.sv
// Picks one virtual card's request for the host link.
// The highest-index card wins when several strobe together.
// Address and data hold until the next request.

`timescale 1ns/1ns

module sd_request_mux (
    input  logic                                           clk50m,
    input  logic                                           reset,
    input  disk_pkg::card_req_t [disk_pkg::NUM_DISKS-1:0] card_req,
    output logic [31:0]                                    host_lba,
    output logic [7:0]                                     host_buff_din,
    output logic                                           rd_active,
    output logic                                           wr_active
);
    import disk_pkg::*;

    logic [NUM_DISKS-1:0] rd_vec;
    logic [NUM_DISKS-1:0] wr_vec;

    always_comb begin
        for (int i = 0; i < NUM_DISKS; i++) begin
            rd_vec[i] = card_req[i].rd;
            wr_vec[i] = card_req[i].wr;
        end
    end

    // Activity LEDs follow the strobes directly
    assign rd_active = |rd_vec;
    assign wr_active = |wr_vec;

    // Later loop iterations overwrite earlier ones, giving the higher index priority
    always_ff @(posedge clk50m) begin
        if (reset) begin
            host_lba      <= '0;
            host_buff_din <= '0;
        end else begin
            for (int i = 0; i < NUM_DISKS; i++) begin
                if (rd_vec[i] || wr_vec[i]) begin
                    host_lba      <= card_req[i].lba;
                    host_buff_din <= card_req[i].buff_din;
                end
            end
        end
    end

    // A virtual card never reads and writes a block at once
    a_no_rd_wr_overlap: assert property (
        @(posedge clk50m) disable iff (reset)
        (rd_vec & wr_vec) == '0
    );

endmodule

//--- rtl/host_glue_top.sv
// Host-side glue between the menu, the virtual SD cards and the PDP-11.
// Everything runs on clk50m, there is no back-pressure on any path.
// LED bits 7:5 are tied low.

`timescale 1ns/1ns

module host_glue_top (
    input  logic                                           clk50m,
    input  logic                                           reset,
    input  host_cfg_pkg::host_status_t                     status,
    input  logic [1:0]                                     buttons,
    input  logic                                           ioctl_download,
    input  logic [disk_pkg::NUM_DISKS-1:0]                 img_mounted,
    input  logic [63:0]                                    img_size,
    input  disk_pkg::spi_bus_t [disk_pkg::NUM_DISKS-1:0]  ctl_spi,
    input  logic [disk_pkg::NUM_DISKS-1:0]                 card_miso,
    input  disk_pkg::card_req_t [disk_pkg::NUM_DISKS-1:0] card_req,
    output logic                                           slow_reset,
    output logic                                           vt_reset,
    output host_cfg_pkg::machine_cfg_t                     cfg,
    output disk_pkg::spi_bus_t [disk_pkg::NUM_DISKS-1:0]  card_spi,
    output logic [disk_pkg::NUM_DISKS-1:0]                 ctl_miso,
    output logic [31:0]                                    host_lba,
    output logic [7:0]                                     host_buff_din,
    output logic [7:0]                                     led
);
    import disk_pkg::*;

    logic [NUM_DISKS-1:0] present;
    logic                 rd_active;
    logic                 wr_active;

    // ==================================================
    // Reset and configuration
    // ==================================================

    reset_sequencer u_reset_sequencer (
        .clk50m         (clk50m),
        .reset          (reset),
        .status_reset   (status.reset_req),
        .buttons        (buttons),
        .ioctl_download (ioctl_download),
        .slow_reset     (slow_reset),
        .vt_reset       (vt_reset)
    );

    option_decoder u_option_decoder (
        .clk50m (clk50m),
        .reset  (reset),
        .status (status),
        .cfg    (cfg)
    );

    // ==================================================
    // Disk paths
    // ==================================================

    disk_presence u_disk_presence (
        .clk50m      (clk50m),
        .reset       (reset),
        .img_mounted (img_mounted),
        .img_size    (img_size),
        .ctl_spi     (ctl_spi),
        .card_miso   (card_miso),
        .card_spi    (card_spi),
        .ctl_miso    (ctl_miso),
        .present     (present)
    );

    sd_request_mux u_sd_request_mux (
        .clk50m        (clk50m),
        .reset         (reset),
        .card_req      (card_req),
        .host_lba      (host_lba),
        .host_buff_din (host_buff_din),
        .rd_active     (rd_active),
        .wr_active     (wr_active)
    );

    // Presence in the low three bits, then read and write activity
    assign led = {3'b000, wr_active, rd_active,
                  present[DISK_RH], present[DISK_RK], present[DISK_RL]};

endmodule

//--- sim/host_glue_tb.sv
// Directed testbench for the host glue top level.
// Inputs change on the falling clk50m edge and outputs are sampled on a later falling edge.
// The cycle limit allows for three full reset stretches and the shorter tests.

`timescale 1ns/1ns

module host_glue_tb;
    import host_cfg_pkg::*;
    import disk_pkg::*;

    localparam int STRETCH_EDGES = 4096;
    localparam int CYCLE_LIMIT   = 3 * STRETCH_EDGES + 2000;

    logic                      clk50m;
    logic                      reset;
    host_status_t              status;
    logic [1:0]                buttons;
    logic                      ioctl_download;
    logic [NUM_DISKS-1:0]      img_mounted;
    logic [63:0]               img_size;
    spi_bus_t [NUM_DISKS-1:0]  ctl_spi;
    logic [NUM_DISKS-1:0]      card_miso;
    card_req_t [NUM_DISKS-1:0] card_req;
    logic                      slow_reset;
    logic                      vt_reset;
    machine_cfg_t              cfg;
    spi_bus_t [NUM_DISKS-1:0]  card_spi;
    logic [NUM_DISKS-1:0]      ctl_miso;
    logic [31:0]               host_lba;
    logic [7:0]                host_buff_din;
    logic [7:0]                led;

    int          error_count;
    int          cycle_count;
    logic [31:0] lcg_state;

    host_glue_top dut (
        .clk50m         (clk50m),
        .reset          (reset),
        .status         (status),
        .buttons        (buttons),
        .ioctl_download (ioctl_download),
        .img_mounted    (img_mounted),
        .img_size       (img_size),
        .ctl_spi        (ctl_spi),
        .card_miso      (card_miso),
        .card_req       (card_req),
        .slow_reset     (slow_reset),
        .vt_reset       (vt_reset),
        .cfg            (cfg),
        .card_spi       (card_spi),
        .ctl_miso       (ctl_miso),
        .host_lba       (host_lba),
        .host_buff_din  (host_buff_din),
        .led            (led)
    );

    initial clk50m = 1'b0;
    always #10 clk50m = ~clk50m;

    // ==================================================
    // Reporting and reference models
    // ==================================================

    task automatic report_mismatch(input string name, input logic [63:0] expected,
                                   input logic [63:0] actual);
        error_count++;
        $display("FAILED at %0t ns: %s expected 0x%0h, got 0x%0h", $time, name, expected, actual);
    endtask

    task automatic report_problem(input string what);
        error_count++;
        $display("ERROR at %0t ns: %s", $time, what);
    endtask

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // CPU models 11/20 up to 11/94, the two spare selections act as 11/94
    function automatic logic [7:0] expected_model(input logic [2:0] sel);
        case (sel)
            3'd0:    return 8'd20;
            3'd1:    return 8'd34;
            3'd2:    return 8'd44;
            3'd3:    return 8'd45;
            3'd4:    return 8'd70;
            default: return 8'd94;
        endcase
    endfunction

    function automatic logic [12:0] expected_timeout(input logic [2:0] sel);
        case (sel)
            3'd0:    return 13'd0;
            3'd1:    return 13'd60;
            3'd2:    return 13'd120;
            3'd3:    return 13'd240;
            3'd4:    return 13'd600;
            3'd5:    return 13'd1200;
            3'd6:    return 13'd3600;
            default: return 13'd7200;
        endcase
    endfunction

    // ==================================================
    // Reset stretch
    // ==================================================

    // Starts on the falling edge where the last reset source drops
    task automatic measure_stretch(input string source);
        int edges;
        edges = 0;
        if (!slow_reset || !vt_reset)
            report_problem({"resets were already low when ", source, " dropped"});
        while (slow_reset && edges <= STRETCH_EDGES + 8) begin
            @(posedge clk50m);
            edges++;
            @(negedge clk50m);
            if (vt_reset !== slow_reset) report_mismatch("vt_reset", slow_reset, vt_reset);
        end
        if (edges != STRETCH_EDGES) report_mismatch({"stretch edges after ", source},
                                                    STRETCH_EDGES, edges);
    endtask

    task automatic check_reset_stretch();
        measure_stretch("reset");
        ioctl_download = 1'b1;
        @(negedge clk50m);
        ioctl_download = 1'b0;
        measure_stretch("ioctl_download");
        status.reset_req = 1'b1;
        repeat (20) begin
            @(negedge clk50m);
            if (!slow_reset || !vt_reset) report_problem("resets dropped while reset_req was high");
        end
        status.reset_req = 1'b0;
        measure_stretch("reset_req");
    endtask

    // ==================================================
    // Option decode
    // ==================================================

    task automatic decode_all_options();
        logic [8:0]   sel;
        logic [6:0]   exp_vt;
        machine_cfg_t reset_cfg;
        // Right after reset the decode of an all-zero status is expected
        reset_cfg = {8'd20, 7'd100, 1'b0, 1'b0, 13'd0};
        if (cfg !== reset_cfg) report_mismatch("cfg", reset_cfg, cfg);
        for (int i = 0; i < 512; i++) begin
            sel = i[8:0];
            status = '0;
            status.model_sel = sel[2:0];
            status.screen_off_sel = sel[5:3];
            status.vt105_sel = sel[6];
            status.cursor_block = sel[7];
            status.cursor_blink = sel[8];
            exp_vt = sel[6] ? 7'd105 : 7'd100;
            @(negedge clk50m);
            if (cfg.model_code !== expected_model(sel[2:0]))
                report_mismatch("cfg.model_code", expected_model(sel[2:0]), cfg.model_code);
            if (cfg.screen_off_seconds !== expected_timeout(sel[5:3]))
                report_mismatch("cfg.screen_off_seconds", expected_timeout(sel[5:3]),
                                cfg.screen_off_seconds);
            if (cfg.vt_type !== exp_vt) report_mismatch("cfg.vt_type", exp_vt, cfg.vt_type);
            if (cfg.cursor_block !== sel[7])
                report_mismatch("cfg.cursor_block", sel[7], cfg.cursor_block);
            if (cfg.cursor_blink !== sel[8])
                report_mismatch("cfg.cursor_blink", sel[8], cfg.cursor_blink);
        end
        status = '0;
    endtask

    // ==================================================
    // Disk presence and SPI gating
    // ==================================================

    task automatic mount_image(input int slot, input logic [63:0] size);
        img_size = size;
        img_mounted = '0;
        img_mounted[slot] = 1'b1;
        @(negedge clk50m);
        img_mounted = '0;
        img_size = '0;
    endtask

    task automatic track_mounts();
        if (led[2:0] !== 3'b000) report_mismatch("led[2:0]", 3'b000, led[2:0]);
        mount_image(DISK_RK, 64'd5242880);
        if (led[2:0] !== 3'b010) report_mismatch("led[2:0]", 3'b010, led[2:0]);
        mount_image(DISK_RL, 64'd10485760);
        if (led[2:0] !== 3'b011) report_mismatch("led[2:0]", 3'b011, led[2:0]);
        // A size with only upper bits set still counts as an image
        mount_image(DISK_RH, 64'h0000_0001_0000_0000);
        if (led[2:0] !== 3'b111) report_mismatch("led[2:0]", 3'b111, led[2:0]);
        mount_image(DISK_RK, 64'd0);
        if (led[2:0] !== 3'b101) report_mismatch("led[2:0]", 3'b101, led[2:0]);
    endtask

    task automatic compare_gating(input logic [NUM_DISKS-1:0] expected_present);
        spi_bus_t expected_spi;
        logic     expected_miso;
        for (int i = 0; i < NUM_DISKS; i++) begin
            expected_spi  = expected_present[i] ? ctl_spi[i] : 3'b111;
            expected_miso = expected_present[i] ? card_miso[i] : 1'b1;
            if (card_spi[i] !== expected_spi)
                report_mismatch($sformatf("card_spi[%0d]", i), expected_spi, card_spi[i]);
            if (ctl_miso[i] !== expected_miso)
                report_mismatch($sformatf("ctl_miso[%0d]", i), expected_miso, ctl_miso[i]);
        end
    endtask

    task automatic gate_spi_lines();
        logic [31:0] rnd;
        ctl_spi = '0;
        card_miso = '0;
        @(negedge clk50m);
        compare_gating(3'b101);
        for (int pass = 0; pass < 2; pass++) begin
            if (pass == 1) mount_image(DISK_RK, 64'd512);
            repeat (8) begin
                rnd = next_random();
                ctl_spi = rnd[31:23];
                card_miso = rnd[22:20];
                @(negedge clk50m);
                compare_gating(pass == 0 ? 3'b101 : 3'b111);
            end
        end
    endtask

    // ==================================================
    // Request selection
    // ==================================================

    task automatic issue_request(input logic [NUM_DISKS-1:0] rd_mask,
                                 input logic [NUM_DISKS-1:0] wr_mask, input int winner);
        logic [31:0] rnd;
        logic [31:0] exp_lba;
        logic [7:0]  exp_din;
        for (int i = 0; i < NUM_DISKS; i++) begin
            card_req[i].lba = next_random();
            rnd = next_random();
            card_req[i].buff_din = rnd[31:24];
            card_req[i].rd = rd_mask[i];
            card_req[i].wr = wr_mask[i];
        end
        exp_lba = card_req[winner].lba;
        exp_din = card_req[winner].buff_din;
        #5;
        if (led[3] !== |rd_mask) report_mismatch("led[3]", |rd_mask, led[3]);
        if (led[4] !== |wr_mask) report_mismatch("led[4]", |wr_mask, led[4]);
        if (led[7:5] !== 3'b000) report_mismatch("led[7:5]", 3'b000, led[7:5]);
        @(negedge clk50m);
        card_req = '0;
        if (host_lba !== exp_lba) report_mismatch("host_lba", exp_lba, host_lba);
        if (host_buff_din !== exp_din) report_mismatch("host_buff_din", exp_din, host_buff_din);
        @(negedge clk50m);
        if (host_lba !== exp_lba) report_mismatch("host_lba after strobe", exp_lba, host_lba);
        if (host_buff_din !== exp_din)
            report_mismatch("host_buff_din after strobe", exp_din, host_buff_din);
        if (led[4:3] !== 2'b00) report_mismatch("led[4:3]", 2'b00, led[4:3]);
    endtask

    task automatic select_requests();
        for (int i = 0; i < NUM_DISKS; i++) begin
            issue_request(3'b001 << i, 3'b000, i);
            issue_request(3'b000, 3'b001 << i, i);
        end
        issue_request(3'b001, 3'b100, DISK_RH);
        issue_request(3'b011, 3'b000, DISK_RK);
        issue_request(3'b000, 3'b101, DISK_RH);
    endtask

    // ==================================================
    // Run control
    // ==================================================

    task automatic finish_run(input logic timed_out);
        $display("Errors: %0d after %0d cycles", error_count, cycle_count);
        if (error_count == 0 && !timed_out) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk50m);
            cycle_count++;
        end
        $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        finish_run(1'b1);
    end

    initial begin
        error_count = 0;
        lcg_state = 32'd20;
        reset = 1'b1;
        status = '0;
        buttons = '0;
        ioctl_download = 1'b0;
        img_mounted = '0;
        img_size = '0;
        ctl_spi = '0;
        card_miso = '0;
        card_req = '0;
        repeat (2) @(posedge clk50m);
        @(negedge clk50m);
        reset = 1'b0;
        check_reset_stretch();
        decode_all_options();
        track_mounts();
        gate_spi_lines();
        select_requests();
        finish_run(1'b0);
    end

endmodule

//--- Makefile
# Verilator build and run for the PDP-11 host glue

VERILATOR  ?= verilator
TOP        := host_glue_tb
LINT_TOP   := host_glue_top
FILELIST   := pdp11_host_glue.f
OBJ_DIR    := obj_dir
LOG        := sim.log
VFLAGS     := --binary --timing --assert -Wno-fatal
LINT_FLAGS := --lint-only --timing -Wall

SOURCES := $(wildcard rtl/*.sv sim/*.sv)

.PHONY: all run lint clean

all: run

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Done: errors found" $(LOG) || ! grep -q "Done: no errors" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- pdp11_host_glue.f
rtl/host_cfg_pkg.sv
rtl/disk_pkg.sv
rtl/reset_sequencer.sv
rtl/option_decoder.sv
rtl/disk_presence.sv
rtl/sd_request_mux.sv
rtl/host_glue_top.sv
sim/host_glue_tb.sv
